/* include/regex_params.svh */
`ifndef REGEX_PARAMS_SVH
`define REGEX_PARAMS_SVH

// Scanner dimensions
`define REGEX_NUM_CAT 2
`define REGEX_KW_LEN 4
`define REGEX_STATE_W 3
`define REGEX_SID_W 6
`define REGEX_CNT_W 16

// Keywords, first byte in the top byte lane
`define REGEX_KW0 32'h4745_5420
`define REGEX_KW1 32'h776f_7721

// Wishbone word addresses
`define REGEX_WB_ADR_W 4
`define REGEX_ADDR_ENABLE 0
`define REGEX_ADDR_CLEAR 1
`define REGEX_ADDR_COUNT0 2

`endif

/* hdl/regex_pkg.sv */
`include "regex_params.svh"

package regex_pkg;

  // One byte of packet payload
  typedef logic [7:0] char_t;

  // Keyword bytes matched so far, 0 up to the keyword length
  typedef logic [`REGEX_STATE_W-1:0] dfa_state_t;

  // Flow identifier carried with pkt_start
  typedef logic [`REGEX_SID_W-1:0] stream_id_t;

  // Per-category packet match count
  typedef logic [`REGEX_CNT_W-1:0] count_t;

endpackage

/* hdl/keyword_dfa.sv */
`timescale 1ns/1ps

`include "regex_params.svh"

module keyword_dfa
  import regex_pkg::*;
#(
  parameter logic [8*`REGEX_KW_LEN-1:0] KEYWORD = `REGEX_KW0
)
(
  input  logic       clk,
  input  logic       rst_n,
  input  char_t      char_in,
  input  logic       char_vld,
  input  dfa_state_t state_in,
  input  logic       state_in_vld,
  output dfa_state_t state_out,
  output logic       accept_out
);

  localparam dfa_state_t FULL = dfa_state_t'(`REGEX_KW_LEN);

  dfa_state_t state_r;
  dfa_state_t base_state;
  dfa_state_t next_state;

  // Keyword byte expected after idx bytes have matched
  function automatic char_t kw_byte(input dfa_state_t idx);
    char_t b;
    b = '0;
    if (idx < FULL)
    begin
      b = KEYWORD[8*(`REGEX_KW_LEN-1-idx) +: 8];
    end
    return b;
  endfunction

  // Restored state takes effect before this cycle's character
  assign base_state = state_in_vld ? state_in : state_r;

  always_comb
  begin
    next_state = base_state;
    if (char_vld)
    begin
      // Advance on the expected byte, else fall back to first byte or idle
      if ((base_state < FULL) && (char_in == kw_byte(base_state)))
        next_state = base_state + dfa_state_t'(1);
      else if (char_in == kw_byte('0))
        next_state = dfa_state_t'(1);
      else
        next_state = '0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      state_r <= '0;
    else
      state_r <= next_state;
  end

  assign state_out  = next_state;
  // Accept only on a real character completing the keyword
  assign accept_out = char_vld && (next_state == FULL);

endmodule

/* hdl/regex_category.sv */
`timescale 1ns/1ps

`include "regex_params.svh"

module regex_category
  import regex_pkg::*;
#(
  parameter logic [8*`REGEX_KW_LEN-1:0] KEYWORD = `REGEX_KW0
)
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       load_state,
  input  logic       new_stream_id,
  input  stream_id_t stream_id,
  input  char_t      char_in,
  input  logic       char_vld,
  input  logic       eop,
  input  logic       enable,
  input  logic       count_clr,
  output count_t     count,
  output logic       fired
);

  // Saved DFA state per stream
  dfa_state_t state_mem [0:(1<<`REGEX_SID_W)-1];

  // DFA input registers
  dfa_state_t state_in;
  logic       state_in_vld_r;
  char_t      char_in_r;
  logic       char_vld_r;

  // DFA outputs, raw and registered
  dfa_state_t state_out;
  logic       accept_out;
  dfa_state_t state_out_r;
  logic       accept_out_r;

  // eop lined up with the last registered DFA result
  logic [2:0] eop_dly;

  // Restore path, zero state for a stream not seen before
  always_ff @(posedge clk)
  begin
    if (load_state)
      state_in <= new_stream_id ? dfa_state_t'(0) : state_mem[stream_id];
    char_in_r   <= char_in;
    state_out_r <= state_out;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_in_vld_r <= 1'b0;
      char_vld_r     <= 1'b0;
      accept_out_r   <= 1'b0;
      eop_dly        <= '0;
    end
    else
    begin
      state_in_vld_r <= load_state;
      char_vld_r     <= char_vld;
      accept_out_r   <= accept_out;
      eop_dly        <= {eop_dly[1:0], eop};
    end
  end

  keyword_dfa #(
    .KEYWORD (KEYWORD)
  ) u_dfa (
    .clk          (clk),
    .rst_n        (rst_n),
    .char_in      (char_in_r),
    .char_vld     (char_vld_r),
    .state_in     (state_in),
    .state_in_vld (state_in_vld_r),
    .state_out    (state_out),
    .accept_out   (accept_out)
  );

  // Sticky match flag and end-of-packet count update
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      fired <= 1'b0;
      count <= '0;
    end
    else
    begin
      if (load_state)
        fired <= 1'b0;
      if (accept_out_r)
        fired <= 1'b1;
      if (eop_dly[2])
      begin
        if (enable)
          count <= count + count_t'(fired);
        else
          fired <= 1'b0;
      end
      // Bus clear wins over a same-cycle update
      if (count_clr)
        count <= '0;
    end
  end

  // Only an enabled category carries its state into the next packet
  always_ff @(posedge clk)
  begin
    if (eop_dly[2] && enable)
      state_mem[stream_id] <= state_out_r;
  end

  // Next packet must not start before the previous save is done
  assert property (@(posedge clk) disable iff (!rst_n) load_state |-> (eop_dly == '0));

  // No byte in the pkt_start cycle, it would beat the restored state
  assert property (@(posedge clk) disable iff (!rst_n) !(char_vld_r && load_state));

endmodule

/* hdl/stream_tracker.sv */
`timescale 1ns/1ps

`include "regex_params.svh"

module stream_tracker
  import regex_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       pkt_start,
  input  stream_id_t stream_id,
  input  logic       table_clr,
  output logic       load_state,
  output logic       new_stream_id,
  output stream_id_t stream_id_r
);

  // One bit per stream id, set once a packet of that id is seen
  logic [(1<<`REGEX_SID_W)-1:0] seen;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      seen       <= '0;
      load_state <= 1'b0;
    end
    else
    begin
      load_state <= pkt_start;
      if (table_clr)
        seen <= '0;
      // Marking after the clear keeps a same-cycle start tracked
      if (pkt_start)
        seen[stream_id] <= 1'b1;
    end
  end

  // Id held for the whole packet, categories save under it at eop
  always_ff @(posedge clk)
  begin
    if (pkt_start)
    begin
      stream_id_r   <= stream_id;
      new_stream_id <= table_clr || !seen[stream_id];
    end
  end

endmodule

/* hdl/regex_wb_regs.sv */
`timescale 1ns/1ps

`include "regex_params.svh"

module regex_wb_regs
  import regex_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           wb_cyc,
  input  logic                           wb_stb,
  input  logic                           wb_we,
  input  logic [`REGEX_WB_ADR_W-1:0]     wb_adr,
  input  logic [31:0]                    wb_dat_i,
  input  logic [3:0]                     wb_sel,
  output logic [31:0]                    wb_dat_o,
  output logic                           wb_ack,
  input  count_t [`REGEX_NUM_CAT-1:0]    counts,
  output logic [`REGEX_NUM_CAT-1:0]      enable,
  output logic                           table_clr,
  output logic                           count_clr
);

  logic        access;
  logic [31:0] rd_data;

  // New access only while ack is low, so each takes two cycles
  assign access = wb_cyc && wb_stb && !wb_ack;

  // Read mux returns zero for unmapped words
  always_comb
  begin
    rd_data = '0;
    if (wb_adr == `REGEX_WB_ADR_W'(`REGEX_ADDR_ENABLE))
      rd_data = 32'(enable);
    for (int c = 0; c < `REGEX_NUM_CAT; c++)
    begin
      if (wb_adr == `REGEX_WB_ADR_W'(`REGEX_ADDR_COUNT0 + c))
        rd_data = 32'(counts[c]);
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wb_ack    <= 1'b0;
      enable    <= '0;
      table_clr <= 1'b0;
      count_clr <= 1'b0;
    end
    else
    begin
      wb_ack    <= access;
      // Clears are single-cycle strobes
      table_clr <= 1'b0;
      count_clr <= 1'b0;
      if (access && wb_we && wb_sel[0])
      begin
        if (wb_adr == `REGEX_WB_ADR_W'(`REGEX_ADDR_ENABLE))
          enable <= wb_dat_i[`REGEX_NUM_CAT-1:0];
        if (wb_adr == `REGEX_WB_ADR_W'(`REGEX_ADDR_CLEAR))
        begin
          table_clr <= wb_dat_i[0];
          count_clr <= wb_dat_i[1];
        end
      end
    end
  end

  // Read data captured with the ack
  always_ff @(posedge clk)
  begin
    if (access)
      wb_dat_o <= rd_data;
  end

  // Strobe from the master is only valid inside a bus cycle
  assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc);

endmodule

/* hdl/regex_scan_top.sv */
`timescale 1ns/1ps

`include "regex_params.svh"

module regex_scan_top
  import regex_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         pkt_start,
  input  stream_id_t                   stream_id,
  input  logic                         char_vld,
  input  char_t                        char_in,
  input  logic                         eop,
  input  logic                         wb_cyc,
  input  logic                         wb_stb,
  input  logic                         wb_we,
  input  logic [`REGEX_WB_ADR_W-1:0]   wb_adr,
  input  logic [31:0]                  wb_dat_i,
  input  logic [3:0]                   wb_sel,
  output logic [31:0]                  wb_dat_o,
  output logic                         wb_ack,
  output logic [`REGEX_NUM_CAT-1:0]    fired
);

  // Keyword of category c sits in lane c
  localparam logic [32*`REGEX_NUM_CAT-1:0] KW_TABLE = {`REGEX_KW1, `REGEX_KW0};

  logic                         load_state;
  logic                         new_stream_id;
  stream_id_t                   stream_id_r;
  logic                         table_clr;
  logic                         count_clr;
  logic [`REGEX_NUM_CAT-1:0]    enable;
  count_t [`REGEX_NUM_CAT-1:0]  counts;

  stream_tracker u_tracker (
    .clk           (clk),
    .rst_n         (rst_n),
    .pkt_start     (pkt_start),
    .stream_id     (stream_id),
    .table_clr     (table_clr),
    .load_state    (load_state),
    .new_stream_id (new_stream_id),
    .stream_id_r   (stream_id_r)
  );

  // All categories scan the same byte stream
  for (genvar gi = 0; gi < `REGEX_NUM_CAT; gi++)
  begin : g_cat
    regex_category #(
      .KEYWORD (KW_TABLE[32*gi +: 32])
    ) u_cat (
      .clk           (clk),
      .rst_n         (rst_n),
      .load_state    (load_state),
      .new_stream_id (new_stream_id),
      .stream_id     (stream_id_r),
      .char_in       (char_in),
      .char_vld      (char_vld),
      .eop           (eop),
      .enable        (enable[gi]),
      .count_clr     (count_clr),
      .count         (counts[gi]),
      .fired         (fired[gi])
    );
  end

  regex_wb_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_i  (wb_dat_i),
    .wb_sel    (wb_sel),
    .wb_dat_o  (wb_dat_o),
    .wb_ack    (wb_ack),
    .counts    (counts),
    .enable    (enable),
    .table_clr (table_clr),
    .count_clr (count_clr)
  );

endmodule

/* dv/regex_scan_tb.sv */
`timescale 1ns/1ps

`include "regex_params.svh"

module regex_scan_tb
  import regex_pkg::*;
();

  localparam int CLK_PERIOD    = 8;
  localparam int NUM_CAT       = `REGEX_NUM_CAT;
  localparam int KW_LEN        = `REGEX_KW_LEN;
  localparam int NUM_STREAMS   = 1 << `REGEX_SID_W;
  localparam int NUM_RAND_PKTS = 40;
  // 13 directed packets plus the random ones
  localparam int NUM_PKTS      = 13 + NUM_RAND_PKTS;
  // Category c keyword in lane c with the first byte on top
  localparam logic [32*NUM_CAT-1:0] KEYWORDS = {`REGEX_KW1, `REGEX_KW0};

  logic                        clk;
  logic                        rst_n;
  logic                        pkt_start;
  stream_id_t                  stream_id;
  logic                        char_vld;
  char_t                       char_in;
  logic                        eop;
  logic                        wb_cyc;
  logic                        wb_stb;
  logic                        wb_we;
  logic [`REGEX_WB_ADR_W-1:0]  wb_adr;
  logic [31:0]                 wb_dat_i;
  logic [3:0]                  wb_sel;
  logic [31:0]                 wb_dat_o;
  logic                        wb_ack;
  logic [NUM_CAT-1:0]          fired;

  // Reference model per stream and category
  int                 model_state [NUM_STREAMS][NUM_CAT];
  bit                 model_seen [NUM_STREAMS];
  int                 model_count [NUM_CAT];
  logic [NUM_CAT-1:0] model_enable;
  logic [NUM_CAT-1:0] model_fired;
  int                 errors;
  int                 checks;
  int                 packets_sent;

  regex_scan_top u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .pkt_start (pkt_start),
    .stream_id (stream_id),
    .char_vld  (char_vld),
    .char_in   (char_in),
    .eop       (eop),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_i  (wb_dat_i),
    .wb_sel    (wb_sel),
    .wb_dat_o  (wb_dat_o),
    .wb_ack    (wb_ack),
    .fired     (fired)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // Budget of 200 cycles per packet plus slack for bus traffic
  initial
  begin
    #((200*NUM_PKTS + 2000) * CLK_PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("Checks failed");
    $finish;
  end

  task automatic check_value(input string what, input int got, input int exp);
    checks++;
    assert (got == exp)
    else
    begin
      errors++;
      $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // One classic cycle held until ack or until a bounded wait runs out
  task automatic bus_cycle(input logic we, input int adr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    int waited;
    waited = 0;
    @(posedge clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr[`REGEX_WB_ADR_W-1:0];
    wb_dat_i = wdata;
    wb_sel   = 4'hf;
    while (!wb_ack && waited < 16)
    begin
      @(posedge clk);
      #1;
      waited++;
    end
    assert (wb_ack)
    else
    begin
      errors++;
      $display("Bus access to word %0d was never acknowledged", adr);
    end
    rdata  = wb_dat_o;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input int adr, input logic [31:0] data);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input int adr, output logic [31:0] data);
    bus_cycle(1'b0, adr, 32'h0, data);
  endtask

  task automatic set_enable(input logic [NUM_CAT-1:0] bits);
    wb_write(`REGEX_ADDR_ENABLE, 32'(bits));
    model_enable = bits;
  endtask

  // Bit 0 forgets all streams and bit 1 zeroes counts
  task automatic clear_ctrl(input logic [1:0] bits);
    wb_write(`REGEX_ADDR_CLEAR, 32'(bits));
    if (bits[0])
      foreach (model_seen[i])
        model_seen[i] = 1'b0;
    if (bits[1])
      foreach (model_count[c])
        model_count[c] = 0;
  endtask

  task automatic check_counts();
    logic [31:0] d;
    for (int c = 0; c < NUM_CAT; c++)
    begin
      wb_read(`REGEX_ADDR_COUNT0 + c, d);
      check_value($sformatf("count %0d", c), int'(d), model_count[c]);
    end
  endtask

  function automatic char_t kw_char(input int cat, input int idx);
    return KEYWORDS[32*cat + 8*(KW_LEN-1-idx) +: 8];
  endfunction

  // Matched-prefix length after one more byte
  function automatic int step_state(input int cat, input int st, input char_t b);
    if (st < KW_LEN && b == kw_char(cat, st))
      return st + 1;
    if (b == kw_char(cat, 0))
      return 1;
    return 0;
  endfunction

  task automatic model_packet(input int id, input char_t bytes[$]);
    int st;
    bit hit;
    for (int c = 0; c < NUM_CAT; c++)
    begin
      st  = model_seen[id] ? model_state[id][c] : 0;
      hit = 1'b0;
      foreach (bytes[i])
      begin
        st = step_state(c, st, bytes[i]);
        if (st == KW_LEN)
          hit = 1'b1;
      end
      // Disabled category keeps its old count and saved state
      if (model_enable[c])
      begin
        model_count[c] += int'(hit);
        model_state[id][c] = st;
      end
      // Flag stays up after eop only in an enabled category
      model_fired[c] = hit && model_enable[c];
    end
    model_seen[id] = 1'b1;
  endtask

  // Start pulse then bytes from the next cycle with eop on the last byte and an idle gap
  task automatic send_packet(input int id, input char_t bytes[$]);
    @(posedge clk);
    #1;
    pkt_start = 1'b1;
    stream_id = stream_id_t'(id);
    @(posedge clk);
    #1;
    pkt_start = 1'b0;
    foreach (bytes[i])
    begin
      char_vld = 1'b1;
      char_in  = bytes[i];
      eop      = (i == bytes.size() - 1);
      @(posedge clk);
      #1;
    end
    char_vld = 1'b0;
    eop      = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    model_packet(id, bytes);
    check_value("fired flags", int'(fired), int'(model_fired));
    packets_sent++;
  endtask

  task automatic send_text(input int id, input string s);
    char_t q[$];
    for (int i = 0; i < s.len(); i++)
      q.push_back(s[i]);
    send_packet(id, q);
  endtask

  // Any byte except a keyword's first byte
  function automatic char_t random_filler();
    char_t b;
    b = char_t'($urandom_range(0, 255));
    while (b == kw_char(0, 0) || b == kw_char(1, 0))
      b = char_t'($urandom_range(0, 255));
    return b;
  endfunction

  // Mix of filler, whole keywords and keyword halves
  task automatic send_random_packet();
    char_t q[$];
    int    id;
    int    len;
    int    cat;
    int    sel;
    id  = $urandom_range(0, 7);
    len = $urandom_range(4, 14);
    while (q.size() < len)
    begin
      sel = $urandom_range(0, 5);
      cat = $urandom_range(0, NUM_CAT-1);
      if (sel < 3)
        q.push_back(random_filler());
      else
        for (int i = (sel == 5) ? 2 : 0; i < ((sel == 4) ? 2 : KW_LEN); i++)
          q.push_back(kw_char(cat, i));
    end
    send_packet(id, q);
  endtask

  task automatic test_reset_values();
    logic [31:0] d;
    wb_read(`REGEX_ADDR_ENABLE, d);
    check_value("enable after reset", int'(d), 0);
    check_counts();
  endtask

  task automatic test_keyword_counts();
    logic [31:0] d;
    set_enable(2'b11);
    send_text(1, "xxGET yy");
    send_text(2, "wow!");
    send_text(3, "GET wow!");
    // Two hits in one packet still count once
    send_text(4, "wow!..wow!");
    check_counts();
    wb_read(`REGEX_ADDR_COUNT0, d);
    check_value("count 0 total", int'(d), 2);
    wb_read(`REGEX_ADDR_COUNT0 + 1, d);
    check_value("count 1 total", int'(d), 3);
  endtask

  task automatic test_split_keyword();
    send_text(10, "abGE");
    send_text(10, "T xy");
    send_text(11, "abGE");
    send_text(12, "T xy");
    check_counts();
  endtask

  task automatic test_disabled_category();
    logic [31:0] d;
    send_text(20, "zzwo");
    set_enable(2'b01);
    wb_read(`REGEX_ADDR_ENABLE, d);
    check_value("enable readback", int'(d), 1);
    send_text(20, "w!GET ");
    check_counts();
    // Saved prefix "wo" from before the disabled packet completes here
    set_enable(2'b11);
    send_text(20, "w!");
    check_counts();
  endtask

  task automatic test_clear_controls();
    clear_ctrl(2'b10);
    check_counts();
    send_text(10, "abGE");
    clear_ctrl(2'b01);
    send_text(10, "T xy");
    check_counts();
  endtask

  task automatic test_random_packets();
    clear_ctrl(2'b11);
    for (int n = 0; n < NUM_RAND_PKTS; n++)
      send_random_packet();
    check_counts();
  endtask

  initial
  begin
    errors       = 0;
    checks       = 0;
    packets_sent = 0;
    model_enable = '0;
    model_fired  = '0;
    foreach (model_seen[i])
      model_seen[i] = 1'b0;
    foreach (model_state[i, c])
      model_state[i][c] = 0;
    foreach (model_count[c])
      model_count[c] = 0;
    rst_n     = 1'b0;
    pkt_start = 1'b0;
    stream_id = '0;
    char_vld  = 1'b0;
    char_in   = '0;
    eop       = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_i  = '0;
    wb_sel    = '0;
    void'($urandom(32'h5579_c224));
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset_values();
    test_keyword_counts();
    test_split_keyword();
    test_disabled_category();
    test_clear_controls();
    test_random_packets();
    $display("Summary: %0d packets, %0d checks, %0d errors", packets_sent, checks, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

/* sim.f */
+incdir+include
hdl/regex_pkg.sv
hdl/keyword_dfa.sv
hdl/regex_category.sv
hdl/stream_tracker.sv
hdl/regex_wb_regs.sv
hdl/regex_scan_top.sv
dv/regex_scan_tb.sv

/* Bender.yml */
package:
  name: regex_scan

export_include_dirs:
  - include

sources:
  - hdl/regex_pkg.sv
  - hdl/keyword_dfa.sv
  - hdl/regex_category.sv
  - hdl/stream_tracker.sv
  - hdl/regex_wb_regs.sv
  - hdl/regex_scan_top.sv
  - target: simulation
    files:
      - dv/regex_scan_tb.sv
